//--- hw/exu_config.svh
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// Data and PC width.
`define EXU_XLEN 32

// ALU operation code width.
`define EXU_ALU_OP_W 5

// Sequential PC increment.
`define EXU_PC_STEP 4

`define EXU_ECALL_CAUSE 11 // Environment call from M-mode.

`endif

//--- hw/exu_pkg.sv
`include "exu_config.svh"

package exu_pkg;

  typedef logic [`EXU_XLEN-1:0]     word_t;
  typedef logic [`EXU_ALU_OP_W-1:0] alu_op_t;
  typedef logic [2:0]               npc_sel_t;
  typedef logic [1:0]               wb_sel_t;
  typedef logic [1:0]               op1_sel_t;
  typedef logic [3:0]               op2_sel_t;
  typedef logic [1:0]               csr_sel_t;

  localparam alu_op_t ALU_ADD   = 'd0;
  localparam alu_op_t ALU_SUB   = 'd1;
  localparam alu_op_t ALU_AND   = 'd2;
  localparam alu_op_t ALU_OR    = 'd3;
  localparam alu_op_t ALU_XOR   = 'd4;
  localparam alu_op_t ALU_SLL   = 'd5;
  localparam alu_op_t ALU_SRL   = 'd6;
  localparam alu_op_t ALU_SRA   = 'd7;
  localparam alu_op_t ALU_SLT   = 'd8;
  localparam alu_op_t ALU_SLTU  = 'd9;
  localparam alu_op_t ALU_EQ    = 'd10;
  localparam alu_op_t ALU_NE    = 'd11;
  localparam alu_op_t ALU_GE    = 'd12;
  localparam alu_op_t ALU_GEU   = 'd13;
  localparam alu_op_t ALU_PASS2 = 'd14; // csrrw.
  localparam alu_op_t ALU_ANDN  = 'd15; // csrrc.

  localparam npc_sel_t NPC_SEQ    = 3'd0;
  localparam npc_sel_t NPC_JAL    = 3'd1;
  localparam npc_sel_t NPC_JALR   = 3'd2;
  localparam npc_sel_t NPC_BRANCH = 3'd3;
  localparam npc_sel_t NPC_TRAP   = 3'd4; // ecall and mret.

  localparam wb_sel_t WB_ALU  = 2'd0;
  localparam wb_sel_t WB_SNPC = 2'd1; // jal, jalr.
  localparam wb_sel_t WB_DNPC = 2'd2; // auipc.
  localparam wb_sel_t WB_CSR  = 2'd3;

  // Bypass bit positions. Lowest index wins.
  localparam int unsigned SEL_OWN = 0;
  localparam int unsigned SEL_FWD = 1;
  localparam int unsigned OP2_IMM = 0;
  localparam int unsigned OP2_CSR = 1;
  localparam int unsigned OP2_OWN = 2;
  localparam int unsigned OP2_FWD = 3;

endpackage

//--- hw/exu_operand_stage.sv
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_operand_stage (
  input  logic              clock,
  input  logic              reset,
  input  logic              block,
  input  logic              decode_valid,
  input  logic              fence_i,
  input  exu_pkg::word_t    pc,
  input  exu_pkg::word_t    imm,
  input  exu_pkg::word_t    src1,
  input  exu_pkg::word_t    src2,
  input  exu_pkg::word_t    csr_src,
  input  exu_pkg::word_t    forward_data,
  input  exu_pkg::word_t    exu_r_wdata,
  input  logic              clear_pipeline,
  input  exu_pkg::alu_op_t  alu_op,
  input  exu_pkg::op1_sel_t op1_sel,
  input  exu_pkg::op2_sel_t op2_sel,
  input  exu_pkg::csr_sel_t csr_sel,
  input  exu_pkg::npc_sel_t npc_sel,
  input  exu_pkg::wb_sel_t  wb_sel,
  input  logic              csr_cause_sel,
  output exu_pkg::alu_op_t  stage_op,
  output exu_pkg::word_t    operand1,
  output exu_pkg::word_t    operand2,
  output exu_pkg::word_t    stage_pc,
  output exu_pkg::word_t    snpc,
  output exu_pkg::word_t    dnpc,
  output exu_pkg::word_t    csr_buf,
  output exu_pkg::word_t    wsrc,
  output exu_pkg::npc_sel_t stage_npc_sel,
  output exu_pkg::wb_sel_t  stage_wb_sel,
  output logic              stage_cause_sel,
  output logic              npc_valid,
  output logic              clear_cache
);
  import exu_pkg::*;

  word_t op1_next;
  word_t csr_next;
  word_t wsrc_next;
  word_t op2_next;

  // Own result first, then the later stage, then the register file.
  assign op1_next  = op1_sel[SEL_OWN] ? exu_r_wdata :
                     op1_sel[SEL_FWD] ? forward_data : src1;
  assign csr_next  = csr_sel[SEL_OWN] ? exu_r_wdata :
                     csr_sel[SEL_FWD] ? forward_data : csr_src;
  assign wsrc_next = op2_sel[OP2_OWN] ? exu_r_wdata :
                     op2_sel[OP2_FWD] ? forward_data : src2;
  assign op2_next  = op2_sel[OP2_IMM] ? imm :
                     op2_sel[OP2_CSR] ? csr_next : wsrc_next;

  always_ff @(posedge clock) begin
    if (reset) begin
      npc_valid       <= 1'b0;
      clear_cache     <= 1'b0;
      stage_npc_sel   <= NPC_SEQ;
      stage_wb_sel    <= WB_ALU;
      stage_cause_sel <= 1'b0;
      stage_op        <= ALU_ADD;
      operand1        <= '0;
      operand2        <= '0;
      wsrc            <= '0;
      csr_buf         <= '0;
      stage_pc        <= '0;
      snpc            <= '0;
      dnpc            <= '0;
    end else if (!block) begin
      // Squash the slot behind a redirect.
      npc_valid       <= decode_valid && !clear_pipeline;
      clear_cache     <= fence_i; // FENCE.I pulse.
      stage_npc_sel   <= npc_sel;
      stage_wb_sel    <= wb_sel;
      stage_cause_sel <= csr_cause_sel;
      stage_op        <= alu_op;
      operand1        <= op1_next;
      operand2        <= op2_next;
      wsrc            <= wsrc_next;
      csr_buf         <= csr_next;
      stage_pc        <= pc;
      snpc            <= pc + word_t'(`EXU_PC_STEP);
      dnpc            <= pc + imm; // Jump and branch target.
    end
  end

endmodule

//--- hw/exu_alu.sv
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_alu (
  input  exu_pkg::alu_op_t op,
  input  exu_pkg::word_t   operand1,
  input  exu_pkg::word_t   operand2,
  output exu_pkg::word_t   result
);
  import exu_pkg::*;

  localparam int SHAMT_W = $clog2(`EXU_XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;
  logic               equal;

  assign shamt       = operand2[SHAMT_W-1:0];
  assign lt_signed   = $signed(operand1) < $signed(operand2);
  assign lt_unsigned = operand1 < operand2;
  assign equal       = operand1 == operand2;

  always_comb begin
    unique case (op)
      ALU_ADD:   result = operand1 + operand2;
      ALU_SUB:   result = operand1 - operand2;
      ALU_AND:   result = operand1 & operand2;
      ALU_OR:    result = operand1 | operand2;
      ALU_XOR:   result = operand1 ^ operand2;
      ALU_SLL:   result = operand1 << shamt;
      ALU_SRL:   result = operand1 >> shamt;
      ALU_SRA:   result = word_t'($signed(operand1) >>> shamt);
      // Compares give 0 or 1 for the branch test.
      ALU_SLT:   result = word_t'(lt_signed);
      ALU_SLTU:  result = word_t'(lt_unsigned);
      ALU_EQ:    result = word_t'(equal);
      ALU_NE:    result = word_t'(!equal);
      ALU_GE:    result = word_t'(!lt_signed);
      ALU_GEU:   result = word_t'(!lt_unsigned);
      ALU_PASS2: result = operand2;
      ALU_ANDN:  result = operand2 & ~operand1; // Clear CSR bits.
      default:   result = '0;
    endcase
  end

endmodule

//--- hw/exu_redirect.sv
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_redirect (
  input  logic              clock,
  input  logic              reset,
  input  logic              block,
  input  exu_pkg::word_t    alu_result,
  input  exu_pkg::word_t    snpc,
  input  exu_pkg::word_t    dnpc,
  input  exu_pkg::word_t    csr_buf,
  input  exu_pkg::word_t    stage_pc,
  input  exu_pkg::npc_sel_t stage_npc_sel,
  input  exu_pkg::wb_sel_t  stage_wb_sel,
  input  logic              stage_cause_sel,
  input  logic              npc_valid,
  input  logic              clear_cache,
  output exu_pkg::word_t    npc,
  output exu_pkg::word_t    exu_r_wdata,
  output exu_pkg::word_t    csr_wdata1,
  output exu_pkg::word_t    csr_wdata2,
  output logic              clear_pipeline
);
  import exu_pkg::*;

  always_comb begin
    case (stage_npc_sel)
      NPC_SEQ:    npc = snpc;
      NPC_JAL:    npc = dnpc;
      NPC_JALR:   npc = alu_result & ~word_t'(1); // Target is halfword aligned.
      NPC_BRANCH: npc = alu_result[0] ? dnpc : snpc;
      NPC_TRAP:   npc = csr_buf;
      default:    npc = '0;
    endcase
  end

  always_comb begin
    case (stage_wb_sel)
      WB_ALU:  exu_r_wdata = alu_result;
      WB_SNPC: exu_r_wdata = snpc;
      WB_DNPC: exu_r_wdata = dnpc;
      WB_CSR:  exu_r_wdata = csr_buf; // Old CSR value.
      default: exu_r_wdata = alu_result;
    endcase
  end

  // Any taken redirect or FENCE.I flushes.
  assign clear_pipeline = (npc_valid && stage_npc_sel != NPC_SEQ) || clear_cache;

  // CSR writes trail the result by one accepted edge.
  always_ff @(posedge clock) begin
    if (reset) begin
      csr_wdata1 <= '0;
      csr_wdata2 <= '0;
    end else if (!block) begin
      csr_wdata1 <= stage_cause_sel ? word_t'(`EXU_ECALL_CAUSE) : alu_result;
      csr_wdata2 <= stage_pc; // Trap PC.
    end
  end

endmodule

//--- hw/exu_top.sv
`timescale 1ns/1ps

module exu_top (
  input  logic              clock,
  input  logic              reset,
  input  logic              block,
  input  logic              decode_valid,
  input  logic              fence_i,
  input  exu_pkg::word_t    pc,
  input  exu_pkg::word_t    imm,
  input  exu_pkg::word_t    src1,
  input  exu_pkg::word_t    src2,
  input  exu_pkg::word_t    csr_src,
  input  exu_pkg::word_t    forward_data,
  input  exu_pkg::alu_op_t  alu_op,
  input  exu_pkg::op1_sel_t op1_sel,
  input  exu_pkg::op2_sel_t op2_sel,
  input  exu_pkg::csr_sel_t csr_sel,
  input  exu_pkg::npc_sel_t npc_sel,
  input  exu_pkg::wb_sel_t  wb_sel,
  input  logic              csr_cause_sel,
  output exu_pkg::word_t    alu_result,
  output exu_pkg::word_t    npc,
  output logic              npc_valid,
  output exu_pkg::word_t    snpc,
  output exu_pkg::word_t    wsrc,
  output exu_pkg::word_t    exu_r_wdata,
  output exu_pkg::word_t    csr_wdata1,
  output exu_pkg::word_t    csr_wdata2,
  output logic              clear_pipeline,
  output logic              clear_cache
);
  import exu_pkg::*;

  alu_op_t  stage_op;
  word_t    operand1;
  word_t    operand2;
  word_t    stage_pc;
  word_t    dnpc;
  word_t    csr_buf;
  npc_sel_t stage_npc_sel;
  wb_sel_t  stage_wb_sel;
  logic     stage_cause_sel;

  exu_operand_stage u_operand_stage (
    .clock(clock), .reset(reset), .block(block),
    .decode_valid(decode_valid), .fence_i(fence_i),
    .pc(pc), .imm(imm), .src1(src1), .src2(src2), .csr_src(csr_src),
    .forward_data(forward_data), .exu_r_wdata(exu_r_wdata),
    .clear_pipeline(clear_pipeline), .alu_op(alu_op),
    .op1_sel(op1_sel), .op2_sel(op2_sel), .csr_sel(csr_sel),
    .npc_sel(npc_sel), .wb_sel(wb_sel), .csr_cause_sel(csr_cause_sel),
    .stage_op(stage_op), .operand1(operand1), .operand2(operand2),
    .stage_pc(stage_pc), .snpc(snpc), .dnpc(dnpc), .csr_buf(csr_buf),
    .wsrc(wsrc), .stage_npc_sel(stage_npc_sel), .stage_wb_sel(stage_wb_sel),
    .stage_cause_sel(stage_cause_sel), .npc_valid(npc_valid),
    .clear_cache(clear_cache)
  );

  exu_alu u_alu (
    .op(stage_op), .operand1(operand1), .operand2(operand2), .result(alu_result)
  );

  exu_redirect u_redirect (
    .clock(clock), .reset(reset), .block(block),
    .alu_result(alu_result), .snpc(snpc), .dnpc(dnpc), .csr_buf(csr_buf),
    .stage_pc(stage_pc), .stage_npc_sel(stage_npc_sel), .stage_wb_sel(stage_wb_sel),
    .stage_cause_sel(stage_cause_sel), .npc_valid(npc_valid), .clear_cache(clear_cache),
    .npc(npc), .exu_r_wdata(exu_r_wdata), .csr_wdata1(csr_wdata1),
    .csr_wdata2(csr_wdata2), .clear_pipeline(clear_pipeline)
  );

endmodule

//--- tb/exu_clock_gen.sv
`timescale 1ns/1ps

module exu_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

  initial begin
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0; // Released on an edge.
  end

endmodule

//--- tb/exu_asserts.sv
`timescale 1ns/1ps

module exu_asserts (
  input logic           clock,
  input logic           reset,
  input logic           block,
  input logic           fence_i,
  input logic           npc_valid,
  input logic           clear_pipeline,
  input logic           clear_cache,
  input exu_pkg::word_t alu_result,
  input exu_pkg::word_t npc,
  input exu_pkg::word_t snpc,
  input exu_pkg::word_t wsrc,
  input exu_pkg::word_t exu_r_wdata,
  input exu_pkg::word_t csr_wdata1,
  input exu_pkg::word_t csr_wdata2
);

  logic [7*32+2:0] outputs;

  assign outputs = {alu_result, npc, snpc, wsrc, exu_r_wdata, csr_wdata1, csr_wdata2,
                    npc_valid, clear_pipeline, clear_cache};

  reset_clears: assert property (@(posedge clock) $past(reset) |-> !npc_valid && !clear_cache)
    else $error("npc_valid or clear_cache high right after reset");

  // Blocked edge freezes every register.
  block_holds: assert property (@(posedge clock) disable iff (reset)
    !$past(reset) && $past(block) |-> $stable(outputs))
    else $error("output changed across a blocked edge");

  fence_pulse: assert property (@(posedge clock) disable iff (reset)
    !$past(reset) && !$past(block) |-> clear_cache == $past(fence_i))
    else $error("clear_cache does not follow fence_i");

endmodule

//--- tb/exu_tb.sv
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_tb;
  import exu_pkg::*;

  localparam int TEST_CYCLES  = 400;
  localparam int TOTAL_CYCLES = 3 + 10 + 4 * TEST_CYCLES + 5;
  localparam int TIMEOUT_NS   = (TOTAL_CYCLES + 100) * 8;

  logic     clock;
  logic     reset;
  logic     block = 1'b0;
  logic     decode_valid = 1'b0;
  logic     fence_i = 1'b0;
  logic     csr_cause_sel = 1'b0;
  word_t    pc = '0;
  word_t    imm = '0;
  word_t    src1 = '0;
  word_t    src2 = '0;
  word_t    csr_src = '0;
  word_t    forward_data = '0;
  alu_op_t  alu_op = ALU_ADD;
  op1_sel_t op1_sel = '0;
  op2_sel_t op2_sel = '0;
  csr_sel_t csr_sel = '0;
  npc_sel_t npc_sel = NPC_SEQ;
  wb_sel_t  wb_sel = WB_ALU;
  word_t    alu_result, npc, snpc, wsrc, exu_r_wdata, csr_wdata1, csr_wdata2;
  logic     npc_valid, clear_pipeline, clear_cache;

  // Reference model state.
  alu_op_t  m_op;
  word_t    m_op1, m_op2, m_pc, m_snpc, m_dnpc, m_csr, m_wsrc, m_w1, m_w2;
  npc_sel_t m_npc_sel;
  wb_sel_t  m_wb_sel;
  logic     m_cause, m_valid, m_cc;

  logic [31:0] lfsr = 32'd1;
  int          errors = 0;
  int          tests_run = 0;
  int          mode = 0;
  logic        checking = 1'b0;

  exu_clock_gen u_clock_gen (.clock(clock), .reset(reset));

  exu_top dut0 (.*);

  bind exu_top exu_asserts u_asserts (.*);

  // One LFSR step per bit with taps 32 22 2 1.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  function automatic word_t alu_model(input alu_op_t op, input word_t a, input word_t b);
    case (op)
      ALU_ADD:   return a + b;
      ALU_SUB:   return a - b;
      ALU_AND:   return a & b;
      ALU_OR:    return a | b;
      ALU_XOR:   return a ^ b;
      ALU_SLL:   return a << b[4:0];
      ALU_SRL:   return a >> b[4:0];
      ALU_SRA:   return word_t'($signed(a) >>> b[4:0]);
      ALU_SLT:   return word_t'($signed(a) < $signed(b));
      ALU_SLTU:  return word_t'(a < b);
      ALU_EQ:    return word_t'(a == b);
      ALU_NE:    return word_t'(a != b);
      ALU_GE:    return word_t'($signed(a) >= $signed(b));
      ALU_GEU:   return word_t'(a >= b);
      ALU_PASS2: return b;
      ALU_ANDN:  return b & ~a;
      default:   return '0;
    endcase
  endfunction

  function automatic word_t npc_model();
    word_t res;
    res = alu_model(m_op, m_op1, m_op2);
    case (m_npc_sel)
      NPC_SEQ:    return m_snpc;
      NPC_JAL:    return m_dnpc;
      NPC_JALR:   return {res[31:1], 1'b0};
      NPC_BRANCH: return res[0] ? m_dnpc : m_snpc;
      NPC_TRAP:   return m_csr;
      default:    return '0;
    endcase
  endfunction

  function automatic word_t wdata_model();
    case (m_wb_sel)
      WB_SNPC: return m_snpc;
      WB_DNPC: return m_dnpc;
      WB_CSR:  return m_csr;
      default: return alu_model(m_op, m_op1, m_op2);
    endcase
  endfunction

  function automatic logic flush_model();
    return (m_valid && m_npc_sel != NPC_SEQ) || m_cc;
  endfunction

  task automatic model_step();
    word_t rw;
    word_t csr_v;
    word_t ws_v;
    logic  flush;
    rw = wdata_model(); // Values from before the edge.
    flush = flush_model();
    if (reset) begin
      {m_op, m_op1, m_op2, m_pc, m_snpc, m_dnpc, m_csr, m_wsrc, m_w1, m_w2} = '0;
      {m_npc_sel, m_wb_sel, m_cause, m_valid, m_cc} = '0;
    end else if (!block) begin
      m_w1 = m_cause ? word_t'(`EXU_ECALL_CAUSE) : alu_model(m_op, m_op1, m_op2);
      m_w2 = m_pc;
      csr_v = csr_sel[0] ? rw : csr_sel[1] ? forward_data : csr_src;
      ws_v = op2_sel[2] ? rw : op2_sel[3] ? forward_data : src2;
      m_op1 = op1_sel[0] ? rw : op1_sel[1] ? forward_data : src1;
      m_op2 = op2_sel[0] ? imm : op2_sel[1] ? csr_v : ws_v;
      m_csr = csr_v;
      m_wsrc = ws_v;
      m_op = alu_op;
      m_pc = pc;
      m_snpc = pc + word_t'(`EXU_PC_STEP);
      m_dnpc = pc + imm;
      m_npc_sel = npc_sel;
      m_wb_sel = wb_sel;
      m_cause = csr_cause_sel;
      m_valid = decode_valid && !flush;
      m_cc = fence_i;
    end
  endtask

  task automatic drive_inputs();
    block <= (mode == 4) && (rand_bits(2) == 0);
    fence_i <= (mode == 4) && (rand_bits(3) == 0);
    decode_valid <= rand_bits(3) != 0;
    pc <= rand_bits(30) << 2;
    imm <= rand_bits(32);
    src1 <= rand_bits(32);
    src2 <= rand_bits(32);
    csr_src <= rand_bits(32);
    forward_data <= rand_bits(32);
    alu_op <= alu_op_t'(rand_bits(5)); // Codes above ALU_ANDN too.
    op1_sel <= op1_sel_t'(rand_bits(2));
    op2_sel <= op2_sel_t'(rand_bits(4));
    csr_sel <= csr_sel_t'(rand_bits(2));
    npc_sel <= (mode == 1) ? NPC_SEQ : npc_sel_t'(rand_bits(3));
    wb_sel <= (mode >= 3) ? wb_sel_t'(rand_bits(2)) : WB_ALU;
    csr_cause_sel <= (mode >= 3) && (rand_bits(1) != 0);
  endtask

  task automatic compare_output(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // Flags low and sequential targets at zero.
  task automatic check_reset_outputs();
    compare_output("npc_valid", '0, word_t'(npc_valid));
    compare_output("clear_cache", '0, word_t'(clear_cache));
    compare_output("clear_pipeline", '0, word_t'(clear_pipeline));
    compare_output("snpc", '0, snpc);
    compare_output("npc", '0, npc);
  endtask

  task automatic run_test(input int id, input int test_mode, input int cycles, input string label);
    int start;
    start = errors;
    @(posedge clock);
    mode <= test_mode;
    repeat (cycles) @(posedge clock);
    tests_run++;
    $display("Test %0d %s done, %0d mismatches", id, label, errors - start);
  endtask

  always @(posedge clock) begin
    model_step();
    if (mode != 0) drive_inputs();
  end

  // Outputs are settled by the falling edge.
  always @(negedge clock) begin
    if (checking) begin
      compare_output("alu_result", alu_model(m_op, m_op1, m_op2), alu_result);
      compare_output("npc", npc_model(), npc);
      compare_output("npc_valid", word_t'(m_valid), word_t'(npc_valid));
      compare_output("snpc", m_snpc, snpc);
      compare_output("wsrc", m_wsrc, wsrc);
      compare_output("exu_r_wdata", wdata_model(), exu_r_wdata);
      compare_output("csr_wdata1", m_w1, csr_wdata1);
      compare_output("csr_wdata2", m_w2, csr_wdata2);
      compare_output("clear_pipeline", word_t'(flush_model()), word_t'(clear_pipeline));
      compare_output("clear_cache", word_t'(m_cc), word_t'(clear_cache));
    end
  end

  initial begin
    @(negedge reset);
    checking = 1'b1;
    @(negedge clock);
    check_reset_outputs();
    run_test(1, 0, 10, "reset");
    run_test(2, 1, TEST_CYCLES, "alu and operand sources");
    run_test(3, 2, TEST_CYCLES, "next pc and flush");
    run_test(4, 3, TEST_CYCLES, "write-back and csr path");
    run_test(5, 4, TEST_CYCLES, "block and fence_i");
    $display("Tests run %0d, mismatches %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired before all tests finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+hw
hw/exu_pkg.sv
hw/exu_operand_stage.sv
hw/exu_alu.sv
hw/exu_redirect.sv
hw/exu_top.sv
tb/exu_clock_gen.sv
tb/exu_asserts.sv
tb/exu_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exu_tb -Mdir obj_dir -o exu_sim -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/exu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
  exit 0
fi
echo "Pass message not found in simulator output"
exit 1
